// File: Bender.yml
package:
  name: timeout_unit

sources:
  - rtl/tmo_pkg.sv
  - rtl/tick_divider.sv
  - rtl/timeout_table.sv
  - rtl/expired_queue.sv
  - rtl/timeout_unit.sv
  - target: simulation
    files:
      - sim/tb_timeout_unit.sv

// File: rtl/expired_queue.sv
// queue of expired task ids
// tapped shift register, newest entry at position 0
// saturating entry count, oldest entry dropped when a push finds it full
`timescale 1ns/10ps
`default_nettype none

module expired_queue import tmo_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              push_i,
	input  qid_t              id_i,
	input  logic              pop_i,
	output qid_t              head_o,
	output logic [QCNT_W-1:0] count_o
);

	qid_t              q [QUEUE_DEPTH];
	// position of the oldest entry
	logic [QCNT_W-1:0] last;

	assign last   = count_o - 1'b1;
	assign head_o = (count_o == '0) ? EMPTY_ID : q[last[QADR_W-1:0]];

	// shift stage, entries past the tap simply fall off the end
	always_ff @(posedge clk_i) begin
		if (push_i) begin
			q[0] <= id_i;
			for (int i = 1; i < QUEUE_DEPTH; i++) begin
				q[i] <= q[i-1];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count_o <= '0;
		end else begin
			case ({push_i, pop_i})
				2'b10: begin
					// full queue keeps its count, the oldest entry is lost
					if (count_o != QCNT_W'(QUEUE_DEPTH)) begin
						count_o <= count_o + 1'b1;
					end
				end
				2'b01: begin
					if (count_o != '0) begin
						count_o <= count_o - 1'b1;
					end
				end
				2'b11: begin
					// the new id replaces the popped one unless the push also drops one
					if (count_o == QCNT_W'(QUEUE_DEPTH)) begin
						count_o <= count_o - 1'b1;
					end
				end
				default: begin
					count_o <= count_o;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/tick_divider.sv
// tick divider for the countdown sweeps
// free-running cycle counter and a sweep request held until acknowledged
`timescale 1ns/10ps
`default_nettype none

module tick_divider import tmo_pkg::*; (
	input  logic clk_i,
	input  logic rst_i,
	input  logic sweep_ack_i,
	output logic sweep_req_o
);

	logic [TICK_W-1:0] cnt;
	logic              wrap;

	// last cycle of each tick period
	assign wrap = (cnt == TICK_W'(TICK_DIV - 1));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt         <= '0;
			sweep_req_o <= 1'b0;
		end else begin
			cnt <= wrap ? '0 : cnt + 1'b1;
			// a new tick wins over an acknowledge in the same cycle, and a tick
			// that arrives while a request is still pending merges with it
			if (wrap) begin
				sweep_req_o <= 1'b1;
			end else if (sweep_ack_i) begin
				sweep_req_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/timeout_table.sv
// countdown table of the task timeout unit
// one countdown entry per task id, cleared to inactive after reset
// command FSM for set, query, pop and the periodic decrement sweep
// expired ids are handed to the queue as one-cycle push pulses
`timescale 1ns/10ps
`default_nettype none

module timeout_table import tmo_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  tmo_cmd_t   cmd_i,
	input  logic       sweep_req_i,
	output logic       sweep_ack_o,
	output logic       done_o,
	output tmo_entry_t entry_o,
	output logic       push_o,
	output qid_t       push_id_o,
	output logic       pop_o
);

	// ========================================
	// storage and state
	// ========================================
	tmo_entry_t tbl [NUM_TASKS];
	tbl_state_t state;

	// table index, used as the init and sweep counter and as the command target
	tid_t       ndx;
	tmo_val_t   set_val;

	// entry under the index, read combinationally
	tmo_entry_t cur;
	logic       tbl_we;
	tmo_entry_t tbl_wd;
	logic       expire;

	assign cur = tbl[ndx];

	// an active entry that is already zero runs out on this sweep step
	assign expire = (state == SWEEP) && !cur.inactive && (cur.count == '0);

	// the queue only needs to see that a pop command is executing
	assign pop_o = (state == POP);

	// ========================================
	// table write port
	// ========================================
	always_comb begin
		tbl_we = 1'b0;
		tbl_wd = cur;
		case (state)
			INIT: begin
				tbl_we = 1'b1;
				tbl_wd = '{inactive: 1'b1, count: '0};
			end
			SWEEP: begin
				// inactive entries are left alone
				tbl_we = !cur.inactive;
				// decrement the whole 33-bit entry, so zero wraps to all ones
				// and the borrow sets the inactive flag
				tbl_wd = tmo_entry_t'(cur - 1'b1);
			end
			SET: begin
				tbl_we = 1'b1;
				tbl_wd = '{inactive: 1'b0, count: set_val};
			end
			default: begin
				tbl_we = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (tbl_we) begin
			tbl[ndx] <= tbl_wd;
		end
	end

	// ========================================
	// result and operand registers
	// ========================================
	always_ff @(posedge clk_i) begin
		// query result is loaded on the edge where done_o rises
		if (state == QRY) begin
			entry_o <= cur;
		end
		// id of the entry looked at this cycle, paired with push_o next cycle
		push_id_o <= {{(QID_W - TID_W){1'b0}}, ndx};
		// the set value is held since the command strobe lasts one cycle
		if ((state == IDLE) && cmd_i.set) begin
			set_val <= cmd_i.val;
		end
	end

	// ========================================
	// command FSM
	// ========================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state       <= INIT;
			ndx         <= '0;
			done_o      <= 1'b0;
			sweep_ack_o <= 1'b0;
			push_o      <= 1'b0;
		end else begin
			sweep_ack_o <= 1'b0;
			push_o      <= expire;
			case (state)
				INIT: begin
					// one entry per cycle, then the unit becomes idle
					ndx <= ndx + 1'b1;
					if (ndx == tid_t'(NUM_TASKS - 1)) begin
						done_o <= 1'b1;
						state  <= IDLE;
					end
				end
				IDLE: begin
					// commands come first, a pending sweep waits for one of them
					if (cmd_i.set) begin
						ndx    <= cmd_i.tid;
						done_o <= 1'b0;
						state  <= SET;
					end else if (cmd_i.qry) begin
						ndx    <= cmd_i.tid;
						done_o <= 1'b0;
						state  <= QRY;
					end else if (cmd_i.pop) begin
						done_o <= 1'b0;
						state  <= POP;
					end else if (sweep_req_i) begin
						ndx         <= '0;
						done_o      <= 1'b0;
						sweep_ack_o <= 1'b1;
						state       <= SWEEP;
					end
				end
				SWEEP: begin
					// ascending ids, ndx wraps back to 0 after the last one
					ndx <= ndx + 1'b1;
					if (ndx == tid_t'(NUM_TASKS - 1)) begin
						done_o <= 1'b1;
						state  <= IDLE;
					end
				end
				SET, QRY, POP: begin
					// single-cycle commands, the work happens in this state
					done_o <= 1'b1;
					state  <= IDLE;
				end
				default: begin
					done_o <= 1'b1;
					state  <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/timeout_unit.sv
// top level of the task timeout unit
// tick divider, countdown table and expired queue
`timescale 1ns/10ps
`default_nettype none

module timeout_unit import tmo_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_i,
	input  tmo_cmd_t          cmd_i,
	output logic              done_o,
	output tmo_entry_t        entry_o,
	output qid_t              head_o,
	output logic [QCNT_W-1:0] queue_count_o
);

	// sweep handshake between divider and table
	logic sweep_req;
	logic sweep_ack;

	// table to queue
	logic push;
	qid_t push_id;
	logic pop;

	tick_divider u_tick_divider (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.sweep_ack_i (sweep_ack),
		.sweep_req_o (sweep_req)
	);

	timeout_table u_timeout_table (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cmd_i       (cmd_i),
		.sweep_req_i (sweep_req),
		.sweep_ack_o (sweep_ack),
		.done_o      (done_o),
		.entry_o     (entry_o),
		.push_o      (push),
		.push_id_o   (push_id),
		.pop_o       (pop)
	);

	// head and count go straight to the top-level outputs
	expired_queue u_expired_queue (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.push_i  (push),
		.id_i    (push_id),
		.pop_i   (pop),
		.head_o  (head_o),
		.count_o (queue_count_o)
	);

endmodule

`default_nettype wire

// File: rtl/tmo_pkg.sv
// shared definitions of the task timeout unit
// widths and sizes of the countdown table and the expired queue
// task id, queue entry and countdown value types
// countdown table entry, command struct and table FSM states
`default_nettype none

package tmo_pkg;

	// ========================================
	// sizes and widths
	// ========================================
	localparam int NUM_TASKS   = 32;
	localparam int TID_W       = 5;
	// wider than a task id so that the empty marker cannot be an id
	localparam int QID_W       = 8;
	localparam int QUEUE_DEPTH = 64;
	localparam int QADR_W      = 6;
	// the count runs from 0 to QUEUE_DEPTH inclusive
	localparam int QCNT_W      = 7;
	localparam int TICK_DIV    = 64;
	localparam int TICK_W      = 6;

	// value seen at the queue head while the queue holds nothing
	localparam logic [QID_W-1:0] EMPTY_ID = 8'hFF;

	// ========================================
	// types
	// ========================================
	typedef logic [TID_W-1:0] tid_t;
	typedef logic [QID_W-1:0] qid_t;
	typedef logic [31:0]      tmo_val_t;

	// the inactive flag sits above the count so that a decrement of an active
	// zero count borrows into it and sets it
	typedef struct packed {
		logic     inactive;
		tmo_val_t count;
	} tmo_entry_t;

	// single-cycle command strobes with their operands
	typedef struct packed {
		logic     set;
		logic     qry;
		logic     pop;
		tid_t     tid;
		tmo_val_t val;
	} tmo_cmd_t;

	typedef enum logic [2:0] {INIT, IDLE, SWEEP, SET, QRY, POP} tbl_state_t;

endpackage

`default_nettype wire

// File: sim/tb_timeout_unit.sv
// testbench of the task timeout unit
// clock, reset, LCG, command tasks with retry and timeouts
// scenarios for reset, countdown, expiry order, empty pop and re-arming
`timescale 1ns/10ps
`default_nettype none

module tb_timeout_unit import tmo_pkg::*; ();

	logic              clk_i;
	logic              rst_i;
	tmo_cmd_t          cmd_i;
	logic              done_o;
	tmo_entry_t        entry_o;
	qid_t              head_o;
	logic [QCNT_W-1:0] queue_count_o;
	logic [31:0]       rng;

	timeout_unit dut (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.cmd_i         (cmd_i),
		.done_o        (done_o),
		.entry_o       (entry_o),
		.head_o        (head_o),
		.queue_count_o (queue_count_o)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#20 clk_i = ~clk_i;
		end
	end

	// ========================================
	// helpers
	// ========================================
	function automatic logic [31:0] lcg_next();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAILED %s: expected %0h, actual %0h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic in_range(input string name, input logic [31:0] lo, input logic [31:0] hi,
			input logic [31:0] act);
		assert ((act >= lo) && (act <= hi)) else begin
			$display("FAILED %s: expected %0h..%0h, actual %0h", name, lo, hi, act);
			abort_run();
		end
	endtask

	// outputs are looked at on the falling edge, half a cycle away from any update
	task automatic wait_idle(input string what);
		int n;
		n = 0;
		@(negedge clk_i);
		while (!done_o) begin
			n++;
			if (n > 100) begin
				$display("timed out waiting for the unit to become idle (%s)", what);
				abort_run();
			end
			@(negedge clk_i);
		end
	endtask

	task automatic wait_queue_count(input int cnt);
		int n;
		n = 0;
		@(negedge clk_i);
		while (queue_count_o != QCNT_W'(cnt)) begin
			n++;
			if (n > 2000) begin
				$display("timed out waiting for %0d expired ids in the queue", cnt);
				abort_run();
			end
			@(negedge clk_i);
		end
	endtask

	// a sweep that starts on the edge where the strobe goes high takes the unit
	// out of IDLE, so the strobe is withdrawn and sent again
	task automatic send_cmd(input tmo_cmd_t c, input string what);
		bit taken;
		int tries;
		taken = 1'b0;
		tries = 0;
		while (!taken) begin
			wait_idle(what);
			@(posedge clk_i);
			cmd_i <= c;
			@(negedge clk_i);
			taken = done_o;
			@(posedge clk_i);
			cmd_i <= '0;
			tries++;
			if (!taken && (tries > 4)) begin
				$display("the unit never accepted a %s command", what);
				abort_run();
			end
		end
		wait_idle(what);
	endtask

	task automatic do_set(input tid_t tid, input tmo_val_t val);
		tmo_cmd_t c;
		c = '0;
		c.set = 1'b1;
		c.tid = tid;
		c.val = val;
		send_cmd(c, "set");
	endtask

	task automatic do_qry(input tid_t tid, output tmo_entry_t e);
		tmo_cmd_t c;
		c = '0;
		c.qry = 1'b1;
		c.tid = tid;
		send_cmd(c, "query");
		e = entry_o;
	endtask

	task automatic do_pop();
		tmo_cmd_t c;
		c = '0;
		c.pop = 1'b1;
		send_cmd(c, "pop");
	endtask

	// ========================================
	// scenarios
	// ========================================
	initial begin
		tmo_entry_t e;
		tid_t       tids [4];
		tmo_val_t   last [4];
		int         vals [3];
		int         j;
		int         tmp;
		logic [7:0] exp_tid;

		rst_i = 1'b1;
		cmd_i = '0;
		rng   = 32'h1ec;
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;

		// every entry starts inactive and the queue starts empty
		wait_idle("end of reset");
		for (int t = 0; t < NUM_TASKS; t++) begin
			do_qry(tid_t'(t), e);
			compare("reset inactive", 32'd1, e.inactive);
		end
		compare("reset head", EMPTY_ID, head_o);
		compare("reset count", 32'd0, queue_count_o);

		// large values with the top bit set never run out during the run
		for (int k = 0; k < 4; k++) begin
			tids[k] = tid_t'(16 + 4 * k + (lcg_next() >> 16) % 4);
			last[k] = lcg_next() | 32'h8000_0000;
			do_set(tids[k], last[k]);
			do_qry(tids[k], e);
			compare("set active", 32'd0, e.inactive);
			in_range("set count", 32'd0, last[k], e.count);
			last[k] = e.count;
		end
		for (int r = 0; r < 3; r++) begin
			repeat (150) @(posedge clk_i);
			for (int k = 0; k < 4; k++) begin
				do_qry(tids[k], e);
				compare("countdown active", 32'd0, e.inactive);
				in_range("countdown", 32'd0, last[k], e.count);
				last[k] = e.count;
			end
		end

		// a zero count runs out on the next sweep
		do_set(tid_t'(5), 32'd0);
		wait_queue_count(1);
		compare("expiry head", 32'd5, head_o);
		do_qry(tid_t'(5), e);
		compare("expiry inactive", 32'd1, e.inactive);
		do_pop();
		compare("expiry pop count", 32'd0, queue_count_o);

		// tasks 8 to 10 get the values 0, 4 and 8 in shuffled order
		vals[0] = 0;
		vals[1] = 4;
		vals[2] = 8;
		for (int i = 2; i > 0; i--) begin
			j = int'(lcg_next() % 32'(i + 1));
			tmp = vals[i];
			vals[i] = vals[j];
			vals[j] = tmp;
		end
		for (int i = 0; i < 3; i++) begin
			do_set(tid_t'(8 + i), tmo_val_t'(vals[i]));
		end
		wait_queue_count(3);
		for (int k = 0; k < 3; k++) begin
			exp_tid = 8'd0;
			for (int i = 0; i < 3; i++) begin
				if (vals[i] == 4 * k) begin
					exp_tid = 8'(8 + i);
				end
			end
			compare("order head", exp_tid, head_o);
			do_pop();
			compare("order count", 32'(2 - k), queue_count_o);
		end

		// popping an empty queue changes nothing
		do_pop();
		compare("empty pop head", EMPTY_ID, head_o);
		compare("empty pop count", 32'd0, queue_count_o);

		// one sweep may fall between the set and the query
		do_set(tid_t'(5), 32'd2);
		do_qry(tid_t'(5), e);
		compare("rearm active", 32'd0, e.inactive);
		in_range("rearm count", 32'd1, 32'd2, e.count);
		wait_queue_count(1);
		compare("rearm head", 32'd5, head_o);
		do_qry(tid_t'(5), e);
		compare("rearm expired", 32'd1, e.inactive);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: timeout_unit.f
rtl/tmo_pkg.sv
rtl/tick_divider.sv
rtl/timeout_table.sv
rtl/expired_queue.sv
rtl/timeout_unit.sv
sim/tb_timeout_unit.sv
